//--- common/axi_bridge_pkg.sv
package axi_bridge_pkg;

    // bus widths
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int ID_W    = 4;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;
    localparam int STRB_W  = DATA_W / 8;
    localparam int TYPE_W  = 3;

    // cache line geometry
    localparam int LINE_BEATS = 4;
    localparam int LINE_W     = DATA_W * LINE_BEATS;

    // cache access type asking for a whole line
    localparam logic [TYPE_W-1:0] TYPE_LINE = 3'd4;

    // axi encodings
    localparam logic [SIZE_W-1:0]  SIZE_WORD  = 3'd2;
    localparam logic [BURST_W-1:0] BURST_INCR = 2'd1;

    // port numbers that double as bit 0 of the axi ids
    localparam int PORT_INST = 0;
    localparam int PORT_DATA = 1;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              ce;
        logic              we;
        logic [STRB_W-1:0] sel;
        logic [TYPE_W-1:0] typ;
    } cpu_req_t;

    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [LEN_W-1:0]   len;
        logic [SIZE_W-1:0]  size;
        logic [BURST_W-1:0] burst;
        logic               valid;
    } axi_ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        word_t             data;
        logic [RESP_W-1:0] resp;
        logic              last;
        logic              valid;
    } axi_r_t;

    // write address carries the same fields as read address
    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        word_t             data;
        logic [STRB_W-1:0] strb;
        logic              last;
        logic              valid;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [RESP_W-1:0] resp;
        logic              valid;
    } axi_b_t;

endpackage

//--- axi_master/axi_read_engine.sv
`timescale 1ns/1ns

module axi_read_engine #(
    parameter int PORT_ID = 0
) (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  axi_bridge_pkg::cpu_req_t req_i,
    output logic                     want_o,
    input  logic                     grant_i,
    output axi_bridge_pkg::axi_ar_t  ar_o,
    input  logic                     arready_i,
    input  axi_bridge_pkg::axi_r_t   r_i,
    output logic                     rready_o,
    output axi_bridge_pkg::word_t    rdata_o,
    output logic                     rbeat_o,
    output logic                     stall_o
);
    import axi_bridge_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_t;

    state_t           state_q;
    axi_ar_t          ar_q;
    logic             rready_q;
    logic             rd_req;
    logic [LEN_W-1:0] req_len;
    logic             last_beat;

    // a read is chip enable without write enable
    assign rd_req = req_i.ce && !req_i.we;

    // line read is a 4 beat incr burst, otherwise a single word
    assign req_len = (req_i.typ == TYPE_LINE) ? LEN_W'(LINE_BEATS - 1) : '0;

    // r_i.valid is already qualified by the id bit in the arbiter
    assign rbeat_o   = (state_q == ST_DATA) && r_i.valid && rready_q;
    assign last_beat = rbeat_o && r_i.last;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q  <= ST_IDLE;
            ar_q     <= '0;
            rready_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (rd_req && grant_i) begin
                        ar_q.id    <= ID_W'(PORT_ID);
                        ar_q.addr  <= req_i.addr;
                        ar_q.len   <= req_len;
                        ar_q.size  <= SIZE_WORD;
                        ar_q.burst <= BURST_INCR;
                        ar_q.valid <= 1'b1;
                        state_q    <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    // clear the whole word so the merged AR bus stays clean
                    if (arready_i) begin
                        ar_q     <= '0;
                        rready_q <= 1'b1;
                        state_q  <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (last_beat) begin
                        rready_q <= 1'b0;
                        state_q  <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign want_o   = (state_q == ST_IDLE) && rd_req;
    assign ar_o     = ar_q;
    assign rready_o = rready_q;
    assign rdata_o  = rbeat_o ? r_i.data : '0;

    always_comb begin
        case (state_q)
            ST_IDLE: begin
                stall_o = rd_req;
            end
            ST_ADDR: begin
                stall_o = 1'b1;
            end
            ST_DATA: begin
                // released in the cycle of the rlast beat
                stall_o = !last_beat;
            end
            default: begin
                stall_o = 1'b0;
            end
        endcase
    end

endmodule

//--- axi_master/axi_write_engine.sv
`timescale 1ns/1ns

module axi_write_engine (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  axi_bridge_pkg::cpu_req_t req_i,
    input  axi_bridge_pkg::line_t    wr_line_i,
    output axi_bridge_pkg::axi_aw_t  aw_o,
    input  logic                     awready_i,
    output axi_bridge_pkg::axi_w_t   w_o,
    input  logic                     wready_i,
    input  axi_bridge_pkg::axi_b_t   b_i,
    output logic                     bready_o,
    output logic                     wr_busy_o,
    output logic                     stall_o
);
    import axi_bridge_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_t;

    state_t            state_q;
    logic [1:0]        beat_q;
    logic [ADDR_W-1:0] addr_q;
    logic [LEN_W-1:0]  len_q;
    logic [STRB_W-1:0] strb_q;
    line_t             line_q;

    logic wr_req;
    logic w_fire;
    logic w_last;
    logic b_fire;
    logic busy;

    assign wr_req = req_i.ce && req_i.we;

    // beat counter only needs to reach LINE_BEATS-1
    assign w_last = (state_q == ST_DATA) && (beat_q == len_q[1:0]);
    assign w_fire = (state_q == ST_DATA) && wready_i;
    assign b_fire = (state_q == ST_RESP) && b_i.valid;

    // control
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= ST_IDLE;
            beat_q  <= 2'd0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_req) begin
                        beat_q  <= 2'd0;
                        state_q <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (awready_i) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (w_fire) begin
                        if (w_last) begin
                            state_q <= ST_RESP;
                        end else begin
                            beat_q <= beat_q + 2'd1;
                        end
                    end
                end
                ST_RESP: begin
                    if (b_fire) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // payload captured at start and shifted down per accepted beat
    always_ff @(posedge aclk) begin
        if ((state_q == ST_IDLE) && wr_req) begin
            addr_q <= req_i.addr;
            len_q  <= (req_i.typ == TYPE_LINE) ? LEN_W'(LINE_BEATS - 1) : '0;
            strb_q <= req_i.sel;
            line_q <= wr_line_i;
        end else if (w_fire) begin
            line_q <= {{DATA_W{1'b0}}, line_q[LINE_W-1:DATA_W]};
        end
    end

    always_comb begin
        aw_o.id    = ID_W'(PORT_DATA);
        aw_o.addr  = addr_q;
        aw_o.len   = len_q;
        aw_o.size  = SIZE_WORD;
        aw_o.burst = BURST_INCR;
        aw_o.valid = (state_q == ST_ADDR);
    end

    always_comb begin
        w_o.data  = line_q[DATA_W-1:0];
        w_o.strb  = strb_q;
        w_o.last  = w_last;
        w_o.valid = (state_q == ST_DATA);
    end

    // bready goes up together with the first data beat
    assign bready_o = (state_q == ST_DATA) || (state_q == ST_RESP);

    always_comb begin
        case (state_q)
            ST_IDLE: begin
                busy = wr_req;
            end
            ST_ADDR, ST_DATA: begin
                busy = 1'b1;
            end
            ST_RESP: begin
                busy = !b_fire;
            end
            default: begin
                busy = 1'b0;
            end
        endcase
    end

    assign wr_busy_o = busy;
    assign stall_o   = busy;

endmodule

//--- axi_master/axi_read_arbiter.sv
`timescale 1ns/1ns

module axi_read_arbiter (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    inst_want_i,
    input  logic                    data_want_i,
    input  logic                    wr_busy_i,
    output logic                    inst_grant_o,
    output logic                    data_grant_o,
    input  axi_bridge_pkg::axi_ar_t inst_ar_i,
    input  axi_bridge_pkg::axi_ar_t data_ar_i,
    output axi_bridge_pkg::axi_ar_t ar_o,
    input  axi_bridge_pkg::axi_r_t  r_i,
    output axi_bridge_pkg::axi_r_t  inst_r_o,
    output axi_bridge_pkg::axi_r_t  data_r_o,
    input  logic                    inst_rready_i,
    input  logic                    data_rready_i,
    output logic                    rready_o
);
    import axi_bridge_pkg::*;

    logic grant_q;
    logic ar_free;
    logic rid_data;

    // channel is free only when no AR is pending or about to be
    assign ar_free = !wr_busy_i && !inst_ar_i.valid && !data_ar_i.valid && !grant_q;

    // data port has priority
    assign data_grant_o = ar_free && data_want_i;
    assign inst_grant_o = ar_free && inst_want_i && !data_want_i;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            grant_q <= 1'b0;
        end else begin
            grant_q <= inst_grant_o || data_grant_o;
        end
    end

    // idle engines drive zeros, so OR is enough
    assign ar_o = axi_ar_t'(inst_ar_i | data_ar_i);

    // steer R beats by the low id bit
    assign rid_data = (r_i.id[0] == 1'(PORT_DATA));

    always_comb begin
        inst_r_o       = r_i;
        inst_r_o.valid = r_i.valid && (r_i.id[0] == 1'(PORT_INST));
        data_r_o       = r_i;
        data_r_o.valid = r_i.valid && rid_data;
    end

    assign rready_o = inst_rready_i || data_rready_i;

endmodule

//--- hdl/axi_master_top.sv
`timescale 1ns/1ns

module axi_master_top (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  axi_bridge_pkg::cpu_req_t inst_req_i,
    input  axi_bridge_pkg::cpu_req_t data_req_i,
    input  axi_bridge_pkg::line_t    data_wr_line_i,
    output axi_bridge_pkg::word_t    inst_rdata_o,
    output axi_bridge_pkg::word_t    data_rdata_o,
    output logic                     inst_rbeat_o,
    output logic                     data_rbeat_o,
    output logic                     inst_stall_o,
    output logic                     data_stall_o,
    output axi_bridge_pkg::axi_ar_t  ar_o,
    input  logic                     arready_i,
    input  axi_bridge_pkg::axi_r_t   r_i,
    output logic                     rready_o,
    output axi_bridge_pkg::axi_aw_t  aw_o,
    input  logic                     awready_i,
    output axi_bridge_pkg::axi_w_t   w_o,
    input  logic                     wready_i,
    input  axi_bridge_pkg::axi_b_t   b_i,
    output logic                     bready_o
);
    import axi_bridge_pkg::*;

    logic    inst_want, data_want;
    logic    inst_grant, data_grant;
    axi_ar_t inst_ar, data_ar;
    axi_r_t  inst_r, data_r;
    logic    inst_rready, data_rready;
    logic    data_rd_stall, wr_stall;
    logic    wr_busy;

    axi_read_engine #(
        .PORT_ID(PORT_INST)
    ) u_inst_rd (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .req_i    (inst_req_i),
        .want_o   (inst_want),
        .grant_i  (inst_grant),
        .ar_o     (inst_ar),
        .arready_i(arready_i),
        .r_i      (inst_r),
        .rready_o (inst_rready),
        .rdata_o  (inst_rdata_o),
        .rbeat_o  (inst_rbeat_o),
        .stall_o  (inst_stall_o)
    );

    axi_read_engine #(
        .PORT_ID(PORT_DATA)
    ) u_data_rd (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .req_i    (data_req_i),
        .want_o   (data_want),
        .grant_i  (data_grant),
        .ar_o     (data_ar),
        .arready_i(arready_i),
        .r_i      (data_r),
        .rready_o (data_rready),
        .rdata_o  (data_rdata_o),
        .rbeat_o  (data_rbeat_o),
        .stall_o  (data_rd_stall)
    );

    axi_write_engine u_wr (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .req_i    (data_req_i),
        .wr_line_i(data_wr_line_i),
        .aw_o     (aw_o),
        .awready_i(awready_i),
        .w_o      (w_o),
        .wready_i (wready_i),
        .b_i      (b_i),
        .bready_o (bready_o),
        .wr_busy_o(wr_busy),
        .stall_o  (wr_stall)
    );

    axi_read_arbiter u_arb (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .inst_want_i  (inst_want),
        .data_want_i  (data_want),
        .wr_busy_i    (wr_busy),
        .inst_grant_o (inst_grant),
        .data_grant_o (data_grant),
        .inst_ar_i    (inst_ar),
        .data_ar_i    (data_ar),
        .ar_o         (ar_o),
        .r_i          (r_i),
        .inst_r_o     (inst_r),
        .data_r_o     (data_r),
        .inst_rready_i(inst_rready),
        .data_rready_i(data_rready),
        .rready_o     (rready_o)
    );

    // data port waits on either its read or its write
    assign data_stall_o = data_rd_stall || wr_stall;

endmodule

//--- dv/tb_axi_master.sv
`timescale 1ns/1ns

module tb_axi_master;
    import axi_bridge_pkg::*;

    localparam int    N_TESTS     = 6;
    localparam int    TEST_CYCLES = 200;
    localparam int    TASK_LIMIT  = 150;
    localparam word_t RULE_KEY    = 32'h5A5A0000;

    logic     aclk     = 1'b0;
    logic     aresetn  = 1'b0;
    cpu_req_t inst_req = '0;
    cpu_req_t data_req = '0;
    line_t    wr_line  = '0;
    logic     arready  = 1'b0;
    axi_r_t   r        = '0;
    logic     awready  = 1'b0;
    logic     wready   = 1'b0;
    axi_b_t   b        = '0;

    word_t   inst_rdata, data_rdata;
    logic    inst_rbeat, data_rbeat;
    logic    inst_stall, data_stall;
    axi_ar_t ar;
    axi_aw_t aw;
    axi_w_t  w;
    logic    rready, bready;

    // slave model state
    axi_ar_t    ar_log[$];
    axi_ar_t    rd_pend[$];
    axi_aw_t    aw_log[$];
    axi_w_t     w_log[$];
    int         b_count   = 0;
    int         r_beat    = 0;
    logic [1:0] delay_tab[256];
    logic [7:0] delay_idx = '0;
    logic [1:0] ar_wait   = '0;
    logic [1:0] aw_wait   = '0;
    logic [1:0] w_wait    = '0;

    int errors    = 0;
    int tests_run = 0;

    axi_master_top uut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .inst_req_i    (inst_req),
        .data_req_i    (data_req),
        .data_wr_line_i(wr_line),
        .inst_rdata_o  (inst_rdata),
        .data_rdata_o  (data_rdata),
        .inst_rbeat_o  (inst_rbeat),
        .data_rbeat_o  (data_rbeat),
        .inst_stall_o  (inst_stall),
        .data_stall_o  (data_stall),
        .ar_o          (ar),
        .arready_i     (arready),
        .r_i           (r),
        .rready_o      (rready),
        .aw_o          (aw),
        .awready_i     (awready),
        .w_o           (w),
        .wready_i      (wready),
        .b_i           (b),
        .bready_o      (bready)
    );

    always #5 aclk = ~aclk;

    // word at address A is A xor the key
    function automatic word_t rule_word(input word_t addr, input int beat);
        return (addr + word_t'(4 * beat)) ^ RULE_KEY;
    endfunction

    function automatic logic [1:0] next_delay();
        next_delay = delay_tab[delay_idx];
        delay_idx  = delay_idx + 8'd1;
    endfunction

    function automatic string sig_name(input int port, input string suffix);
        string pfx;
        if (port == PORT_DATA) begin
            pfx = "data_";
        end else begin
            pfx = "inst_";
        end
        return {pfx, suffix};
    endfunction

    // slave model with readies after 0 to 3 extra cycles
    always @(posedge aclk) begin
        if (!aresetn) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            r       <= '0;
            b       <= '0;
        end else begin
            if (r.valid && rready) begin
                if (r.last) begin
                    rd_pend.delete(0);
                    r_beat = 0;
                end else begin
                    r_beat++;
                end
            end
            if (ar.valid && arready) begin
                ar_log.push_back(ar);
                rd_pend.push_back(ar);
                arready <= 1'b0;
                ar_wait <= next_delay();
            end else if (ar.valid) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end
            // reads are served in the order the addresses arrived
            if (rd_pend.size() > 0) begin
                r.id    <= rd_pend[0].id;
                r.data  <= rule_word(rd_pend[0].addr, r_beat);
                r.resp  <= '0;
                r.last  <= (r_beat == int'(rd_pend[0].len));
                r.valid <= 1'b1;
            end else begin
                r <= '0;
            end
            if (b.valid && bready) begin
                b_count++;
                b <= '0;
            end
            if (aw.valid && awready) begin
                aw_log.push_back(aw);
                awready <= 1'b0;
                aw_wait <= next_delay();
            end else if (aw.valid) begin
                if (aw_wait == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end
            if (w.valid && wready) begin
                w_log.push_back(w);
                wready <= 1'b0;
                w_wait <= next_delay();
                if (w.last) begin
                    b.id    <= aw_log[aw_log.size() - 1].id;
                    b.valid <= 1'b1;
                end
            end else if (w.valid) begin
                if (w_wait == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 2'd1;
                end
            end
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_len(input string name, input logic [LEN_W-1:0] got,
                             input logic [LEN_W-1:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%02h expected 0x%02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge aclk);
    endtask

    task automatic finish_test(input int num, input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_start);
        end
        tests_run++;
    endtask

    // request a read, check each beat against the rule, release on the falling stall
    task automatic read_and_check(input int port, input word_t addr,
                                  input logic [TYPE_W-1:0] typ);
        int       beats;
        int       cycles;
        int       want;
        logic     done;
        logic     beat;
        logic     stall;
        word_t    got;
        cpu_req_t req;
        beats  = 0;
        cycles = 0;
        done   = 1'b0;
        want   = (typ == TYPE_LINE) ? LINE_BEATS : 1;
        req      = '0;
        req.addr = addr;
        req.ce   = 1'b1;
        req.typ  = typ;
        @(posedge aclk);
        if (port == PORT_DATA) begin
            data_req <= req;
        end else begin
            inst_req <= req;
        end
        while (!done && cycles < TASK_LIMIT) begin
            @(posedge aclk);
            cycles++;
            beat  = (port == PORT_DATA) ? data_rbeat : inst_rbeat;
            got   = (port == PORT_DATA) ? data_rdata : inst_rdata;
            stall = (port == PORT_DATA) ? data_stall : inst_stall;
            if (cycles == 1) begin
                check_flag(sig_name(port, "stall_o"), stall, 1'b1);
            end
            if (beat) begin
                check_word(sig_name(port, "rdata_o"), got, rule_word(addr, beats));
                beats++;
            end
            if (!stall) begin
                done = 1'b1;
                // stall drops in the cycle of the rlast beat
                check_flag(sig_name(port, "rbeat_o at stall fall"), beat, 1'b1);
                if (port == PORT_DATA) begin
                    data_req <= '0;
                end else begin
                    inst_req <= '0;
                end
            end
        end
        if (!done) begin
            $display("%s read at 0x%08h did not finish within %0d cycles",
                     sig_name(port, "port"), addr, TASK_LIMIT);
            errors++;
        end
        check_len(sig_name(port, "rbeat_o count"), LEN_W'(beats), LEN_W'(want));
    endtask

    task automatic write_and_wait(input word_t addr, input logic [TYPE_W-1:0] typ,
                                  input logic [STRB_W-1:0] sel, input line_t line);
        int       cycles;
        logic     done;
        cpu_req_t req;
        cycles   = 0;
        done     = 1'b0;
        req      = '0;
        req.addr = addr;
        req.ce   = 1'b1;
        req.we   = 1'b1;
        req.sel  = sel;
        req.typ  = typ;
        @(posedge aclk);
        data_req <= req;
        wr_line  <= line;
        while (!done && cycles < TASK_LIMIT) begin
            @(posedge aclk);
            cycles++;
            if (cycles == 1) begin
                check_flag("data_stall_o", data_stall, 1'b1);
            end
            if (!data_stall) begin
                done = 1'b1;
                // stall drops in the cycle of the B handshake
                check_flag("bvalid and bready at stall fall", b.valid && bready, 1'b1);
                data_req <= '0;
            end
        end
        if (!done) begin
            $display("write at 0x%08h did not finish within %0d cycles", addr, TASK_LIMIT);
            errors++;
        end
    endtask

    task automatic watch_ar_until_b();
        int   cycles;
        logic seen_b;
        cycles = 0;
        seen_b = 1'b0;
        while (!seen_b && cycles < TASK_LIMIT) begin
            @(posedge aclk);
            cycles++;
            if (ar.valid) begin
                $display("arvalid was high before the write response at %0t", $time);
                errors++;
            end
            seen_b = b.valid && bready;
        end
    endtask

    task automatic single_word_fetch();
        int err0;
        int ab;
        err0 = errors;
        ab   = ar_log.size();
        read_and_check(PORT_INST, 32'h0000_1000, 3'd0);
        idle_cycles(2);
        check_len("arlen", ar_log[ab].len, LEN_W'(0));
        check_flag("arid[0]", ar_log[ab].id[0], 1'b0);
        check_word("araddr", ar_log[ab].addr, 32'h0000_1000);
        check_len("arsize", LEN_W'(ar_log[ab].size), LEN_W'(2));
        check_len("arburst", LEN_W'(ar_log[ab].burst), LEN_W'(1));
        finish_test(1, "inst word read", err0);
    endtask

    task automatic line_fill();
        int err0;
        int ab;
        err0 = errors;
        ab   = ar_log.size();
        read_and_check(PORT_DATA, 32'h0000_2040, TYPE_LINE);
        idle_cycles(2);
        check_len("arlen", ar_log[ab].len, LEN_W'(3));
        check_flag("arid[0]", ar_log[ab].id[0], 1'b1);
        finish_test(2, "data line read", err0);
    endtask

    task automatic word_store();
        int    err0;
        int    awb;
        int    wb;
        int    bb;
        line_t line;
        err0 = errors;
        awb  = aw_log.size();
        wb   = w_log.size();
        bb   = b_count;
        line = 128'h0123_4567_89ab_cdef_1122_3344_c0de_0042;
        write_and_wait(32'h0000_3010, 3'd2, 4'b0110, line);
        idle_cycles(2);
        check_len("awlen", aw_log[awb].len, LEN_W'(0));
        check_word("awaddr", aw_log[awb].addr, 32'h0000_3010);
        check_flag("awid[0]", aw_log[awb].id[0], 1'b1);
        check_len("awsize", LEN_W'(aw_log[awb].size), LEN_W'(2));
        check_len("awburst", LEN_W'(aw_log[awb].burst), LEN_W'(1));
        check_len("w beat count", LEN_W'(w_log.size() - wb), LEN_W'(1));
        check_word("wdata", w_log[wb].data, line[DATA_W-1:0]);
        check_word("wstrb", word_t'(w_log[wb].strb), word_t'(4'b0110));
        check_flag("wlast", w_log[wb].last, 1'b1);
        check_len("b count", LEN_W'(b_count - bb), LEN_W'(1));
        finish_test(3, "data word write", err0);
    endtask

    task automatic line_writeback();
        int    err0;
        int    awb;
        int    wb;
        line_t line;
        err0 = errors;
        awb  = aw_log.size();
        wb   = w_log.size();
        line = 128'hfeed_0003_beef_0002_cafe_0001_d00d_0000;
        write_and_wait(32'h0000_4000, TYPE_LINE, 4'hf, line);
        idle_cycles(2);
        check_len("awlen", aw_log[awb].len, LEN_W'(3));
        check_word("awaddr", aw_log[awb].addr, 32'h0000_4000);
        check_len("w beat count", LEN_W'(w_log.size() - wb), LEN_W'(LINE_BEATS));
        for (int k = 0; k < LINE_BEATS; k++) begin
            check_word("wdata", w_log[wb + k].data, line[k*DATA_W +: DATA_W]);
            check_flag("wlast", w_log[wb + k].last, k == LINE_BEATS - 1);
        end
        finish_test(4, "data line write", err0);
    endtask

    task automatic dual_read();
        int err0;
        int ab;
        err0 = errors;
        ab   = ar_log.size();
        fork
            read_and_check(PORT_INST, 32'h0000_5000, TYPE_LINE);
            read_and_check(PORT_DATA, 32'h0000_6080, TYPE_LINE);
        join
        idle_cycles(2);
        // data port has priority on the AR channel
        check_flag("first arid[0]", ar_log[ab].id[0], 1'b1);
        check_flag("second arid[0]", ar_log[ab + 1].id[0], 1'b0);
        finish_test(5, "inst and data reads together", err0);
    endtask

    task automatic write_blocks_read();
        int err0;
        int bb;
        err0 = errors;
        bb   = b_count;
        fork
            write_and_wait(32'h0000_7000, TYPE_LINE, 4'hf, 128'h1);
            read_and_check(PORT_INST, 32'h0000_8004, 3'd0);
            watch_ar_until_b();
        join
        idle_cycles(2);
        check_len("b count", LEN_W'(b_count - bb), LEN_W'(1));
        finish_test(6, "write blocks read", err0);
    endtask

    initial begin
        void'($urandom(35415));
        foreach (delay_tab[i]) begin
            delay_tab[i] = 2'($urandom % 4);
        end
        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;
        idle_cycles(2);
        single_word_fetch();
        line_fill();
        word_store();
        line_writeback();
        dual_read();
        write_blocks_read();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (N_TESTS * TEST_CYCLES) @(posedge aclk);
        $display("timeout: tests did not finish within %0d cycles", N_TESTS * TEST_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

//--- sim.f
common/axi_bridge_pkg.sv
axi_master/axi_read_engine.sv
axi_master/axi_write_engine.sv
axi_master/axi_read_arbiter.sv
hdl/axi_master_top.sv
dv/tb_axi_master.sv

//--- Makefile
TOP := tb_axi_master

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o $(TOP)

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
